/* rtl/exu_defines.svh */
`ifndef EXU_DEFINES_SVH
`define EXU_DEFINES_SVH

// datapath width of the integer core.
`define EXU_XLEN 32

// register index width, enough for x0 to x31.
`define EXU_REG_W 5

// shift amount width, taken from the low bits of operand b.
`define EXU_SHAMT_W 5

// value loaded into the redirect target at reset.
`define EXU_DNPC_RST 32'h0000_0000

`endif

/* rtl/exu_pkg.sv */
package exu_pkg;

    typedef enum logic [1:0] {
        CLS_ALU    = 2'd0,
        CLS_BRANCH = 2'd1,
        CLS_JUMP   = 2'd2,
        CLS_SYS    = 2'd3
    } exu_class_e;

    typedef enum logic [3:0] {
        FN_ADD    = 4'd0,
        FN_SUB    = 4'd1,
        FN_SLL    = 4'd2,
        FN_SLT    = 4'd3,
        FN_SLTU   = 4'd4,
        FN_XOR    = 4'd5,
        FN_SRL    = 4'd6,
        FN_SRA    = 4'd7,
        FN_OR     = 4'd8,
        FN_AND    = 4'd9,
        FN_PASS_B = 4'd10 // lui passes the immediate straight through.
    } alu_fn_e;

    typedef enum logic [2:0] {
        CMP_EQ  = 3'd0,
        CMP_NE  = 3'd1,
        CMP_LT  = 3'd2,
        CMP_GE  = 3'd3,
        CMP_LTU = 3'd4,
        CMP_GEU = 3'd5
    } cmp_e;

    typedef struct packed {
        alu_fn_e fn;
        cmp_e    cmp;
        logic    spare;
    } alu_fields_t;

    typedef struct packed {
        logic csrrw;
        logic csrrs;
        logic ecall;
        logic mret;
        logic fence_i;
        logic ebreak;
        logic illegal;
        logic spare;
    } sys_fields_t;

    // one op word, read by field layout according to the instruction class.
    typedef union packed {
        alu_fields_t alu; // alu, branch and jump classes.
        sys_fields_t sys; // system class only.
    } exu_op_u;

endpackage

/* rtl/exu_alu.sv */
`include "exu_defines.svh"

module exu_alu (
    input  logic [`EXU_XLEN-1:0] pc,
    input  logic [`EXU_XLEN-1:0] imm,
    input  logic [`EXU_XLEN-1:0] src1,
    input  logic [`EXU_XLEN-1:0] src2,
    input  logic                 src1_is_pc,
    input  logic                 src2_is_imm,
    input  exu_pkg::exu_class_e  op_class,
    input  exu_pkg::exu_op_u     op,
    output logic [`EXU_XLEN-1:0] alu_result,
    output logic                 cmp_taken
);
    import exu_pkg::*;

    logic [`EXU_XLEN-1:0]    opa;
    logic [`EXU_XLEN-1:0]    opb;
    logic [`EXU_XLEN-1:0]    sum;
    logic [`EXU_XLEN-1:0]    fn_result;
    logic [`EXU_SHAMT_W-1:0] shamt;
    logic                    ab_lt_s;
    logic                    ab_lt_u;
    logic                    src_eq;
    logic                    src_lt_s;
    logic                    src_lt_u;

    assign opa   = src1_is_pc  ? pc  : src1;
    assign opb   = src2_is_imm ? imm : src2;
    assign shamt = opb[`EXU_SHAMT_W-1:0];
    assign sum   = opa + opb;

    assign ab_lt_s = $signed(opa) < $signed(opb);
    assign ab_lt_u = opa < opb;

    always_comb begin
        case (op.alu.fn)
            FN_ADD:    fn_result = sum;
            FN_SUB:    fn_result = opa - opb;
            FN_SLL:    fn_result = opa << shamt;
            FN_SLT:    fn_result = {{(`EXU_XLEN-1){1'b0}}, ab_lt_s};
            FN_SLTU:   fn_result = {{(`EXU_XLEN-1){1'b0}}, ab_lt_u};
            FN_XOR:    fn_result = opa ^ opb;
            FN_SRL:    fn_result = opa >> shamt;
            FN_SRA:    fn_result = $signed(opa) >>> shamt;
            FN_OR:     fn_result = opa | opb;
            FN_AND:    fn_result = opa & opb;
            FN_PASS_B: fn_result = opb;
            default:   fn_result = '0;
        endcase
    end

    always_comb begin
        case (op_class)
            CLS_JUMP: alu_result = {sum[`EXU_XLEN-1:1], 1'b0}; // jalr clears bit 0.
            CLS_SYS:  alu_result = '0; // the op word holds system flags here.
            default:  alu_result = fn_result;
        endcase
    end

    // the branch compare always looks at the register operands.
    assign src_eq   = src1 == src2;
    assign src_lt_s = $signed(src1) < $signed(src2);
    assign src_lt_u = src1 < src2;

    always_comb begin
        case (op.alu.cmp)
            CMP_EQ:  cmp_taken = src_eq;
            CMP_NE:  cmp_taken = !src_eq;
            CMP_LT:  cmp_taken = src_lt_s;
            CMP_GE:  cmp_taken = !src_lt_s;
            CMP_LTU: cmp_taken = src_lt_u;
            CMP_GEU: cmp_taken = !src_lt_u;
            default: cmp_taken = 1'b0;
        endcase
    end

endmodule

/* rtl/exu_branch.sv */
`include "exu_defines.svh"

module exu_branch (
    input  exu_pkg::exu_class_e  op_class,
    input  exu_pkg::exu_op_u     op,
    input  logic                 cmp_taken,
    input  logic [`EXU_XLEN-1:0] alu_result,
    input  logic [`EXU_XLEN-1:0] csr_data,
    output logic                 redirect,
    output logic [`EXU_XLEN-1:0] redirect_pc
);
    import exu_pkg::*;

    logic sys_trap;

    // ecall reads mtvec and mret reads mepc, both arrive on csr_data.
    assign sys_trap = op.sys.ecall | op.sys.mret;

    always_comb begin
        redirect    = 1'b0;
        redirect_pc = alu_result; // pc + imm for branches, rs1 + imm for jalr.
        case (op_class)
            CLS_JUMP: begin
                redirect = 1'b1;
            end
            CLS_BRANCH: begin
                redirect = cmp_taken;
            end
            CLS_SYS: begin
                redirect    = sys_trap;
                redirect_pc = csr_data;
            end
            default: begin
                redirect = 1'b0;
            end
        endcase
    end

endmodule

/* rtl/exu_csr_wdata.sv */
`include "exu_defines.svh"

module exu_csr_wdata (
    input  exu_pkg::exu_class_e  op_class,
    input  exu_pkg::exu_op_u     op,
    input  logic [`EXU_XLEN-1:0] pc,
    input  logic [`EXU_XLEN-1:0] src1,
    input  logic [`EXU_XLEN-1:0] csr_data,
    input  logic [`EXU_XLEN-1:0] alu_result,
    output logic [`EXU_XLEN-1:0] wb_result,
    output logic [`EXU_XLEN-1:0] csr_wdata_next
);
    import exu_pkg::*;

    localparam logic [`EXU_XLEN-1:0] INSN_BYTES = 4;

    logic is_sys;
    logic csr_op;

    assign is_sys = op_class == CLS_SYS;
    assign csr_op = is_sys & (op.sys.csrrw | op.sys.csrrs);

    assign csr_wdata_next = !is_sys       ? '0 :
                            op.sys.csrrw  ? src1 :
                            op.sys.csrrs  ? (src1 | csr_data) : '0;

    assign wb_result = (op_class == CLS_JUMP) ? pc + INSN_BYTES : // link address.
                       csr_op                 ? csr_data : alu_result;

endmodule

/* rtl/exu_ctrl.sv */
`include "exu_defines.svh"

module exu_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  idu_valid,
    input  logic                  lsu_ready,
    input  logic [`EXU_XLEN-1:0]  wb_result,
    input  logic [`EXU_XLEN-1:0]  csr_wdata_next,
    input  logic [`EXU_XLEN-1:0]  src2,
    input  logic                  redirect,
    input  logic [`EXU_XLEN-1:0]  redirect_pc,
    input  exu_pkg::exu_class_e   op_class,
    input  exu_pkg::exu_op_u      op,
    input  logic                  is_load,
    input  logic                  is_store,
    input  logic                  rf_we,
    input  logic [`EXU_REG_W-1:0] rd,
    output logic                  exu_ready,
    output logic                  exu_valid,
    output logic [`EXU_XLEN-1:0]  result,
    output logic [`EXU_XLEN-1:0]  store_data,
    output logic [`EXU_XLEN-1:0]  csr_wdata,
    output logic                  lu_is_load,
    output logic                  lu_is_store,
    output logic                  lu_rf_we,
    output logic [`EXU_REG_W-1:0] lu_rd,
    output logic                  dnpc_valid,
    output logic [`EXU_XLEN-1:0]  dnpc,
    output logic                  ic_fence_i,
    output logic                  halt
);
    import exu_pkg::*;

    logic is_sys;
    logic sys_fence_i;
    logic sys_halt;
    logic accept;

    assign exu_ready = lsu_ready; // one register deep, so it moves whenever memory does.
    assign accept    = idu_valid & lsu_ready;

    assign is_sys      = op_class == CLS_SYS;
    assign sys_fence_i = is_sys & op.sys.fence_i;
    assign sys_halt    = is_sys & (op.sys.ebreak | op.sys.illegal);

    // flags clear on an idle edge and hold while memory stalls.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exu_valid  <= 1'b0;
            dnpc_valid <= 1'b0;
            ic_fence_i <= 1'b0;
            halt       <= 1'b0;
        end else if (lsu_ready) begin
            exu_valid  <= idu_valid;
            dnpc_valid <= idu_valid & redirect;
            ic_fence_i <= idu_valid & sys_fence_i;
            halt       <= idu_valid & sys_halt;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result      <= '0;
            store_data  <= '0;
            csr_wdata   <= '0;
            lu_is_load  <= 1'b0;
            lu_is_store <= 1'b0;
            lu_rf_we    <= 1'b0;
            lu_rd       <= '0;
            dnpc        <= `EXU_DNPC_RST;
        end else if (accept) begin
            result      <= wb_result;
            store_data  <= src2;
            csr_wdata   <= csr_wdata_next;
            lu_is_load  <= is_load;
            lu_is_store <= is_store;
            lu_rf_we    <= rf_we;
            lu_rd       <= rd;
            dnpc        <= redirect_pc; // qualified by dnpc_valid.
        end
    end

endmodule

/* rtl/exu_top.sv */
`include "exu_defines.svh"

module exu_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  idu_valid,
    input  logic [`EXU_XLEN-1:0]  pc,
    input  logic [`EXU_XLEN-1:0]  imm,
    input  logic [`EXU_XLEN-1:0]  src1,
    input  logic [`EXU_XLEN-1:0]  src2,
    input  logic [`EXU_XLEN-1:0]  csr_data,
    input  exu_pkg::exu_class_e   op_class,
    input  exu_pkg::exu_op_u      op,
    input  logic                  src1_is_pc,
    input  logic                  src2_is_imm,
    input  logic                  is_load,
    input  logic                  is_store,
    input  logic                  rf_we,
    input  logic [`EXU_REG_W-1:0] rd,
    input  logic                  lsu_ready,
    output logic                  exu_ready,
    output logic                  exu_valid,
    output logic [`EXU_XLEN-1:0]  result,
    output logic [`EXU_XLEN-1:0]  store_data,
    output logic [`EXU_XLEN-1:0]  csr_wdata,
    output logic                  lu_is_load,
    output logic                  lu_is_store,
    output logic                  lu_rf_we,
    output logic [`EXU_REG_W-1:0] lu_rd,
    output logic                  ic_fence_i,
    output logic                  dnpc_valid,
    output logic [`EXU_XLEN-1:0]  dnpc,
    output logic                  halt
);

    logic [`EXU_XLEN-1:0] alu_result;
    logic                 cmp_taken;
    logic                 redirect;
    logic [`EXU_XLEN-1:0] redirect_pc;
    logic [`EXU_XLEN-1:0] wb_result;
    logic [`EXU_XLEN-1:0] csr_wdata_next;

    exu_alu u_alu (
        .pc          (pc),
        .imm         (imm),
        .src1        (src1),
        .src2        (src2),
        .src1_is_pc  (src1_is_pc),
        .src2_is_imm (src2_is_imm),
        .op_class    (op_class),
        .op          (op),
        .alu_result  (alu_result),
        .cmp_taken   (cmp_taken)
    );

    exu_branch u_branch (
        .op_class    (op_class),
        .op          (op),
        .cmp_taken   (cmp_taken),
        .alu_result  (alu_result),
        .csr_data    (csr_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    exu_csr_wdata u_csr_wdata (
        .op_class       (op_class),
        .op             (op),
        .pc             (pc),
        .src1           (src1),
        .csr_data       (csr_data),
        .alu_result     (alu_result),
        .wb_result      (wb_result),
        .csr_wdata_next (csr_wdata_next)
    );

    exu_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .idu_valid      (idu_valid),
        .lsu_ready      (lsu_ready),
        .wb_result      (wb_result),
        .csr_wdata_next (csr_wdata_next),
        .src2           (src2),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .op_class       (op_class),
        .op             (op),
        .is_load        (is_load),
        .is_store       (is_store),
        .rf_we          (rf_we),
        .rd             (rd),
        .exu_ready      (exu_ready),
        .exu_valid      (exu_valid),
        .result         (result),
        .store_data     (store_data),
        .csr_wdata      (csr_wdata),
        .lu_is_load     (lu_is_load),
        .lu_is_store    (lu_is_store),
        .lu_rf_we       (lu_rf_we),
        .lu_rd          (lu_rd),
        .dnpc_valid     (dnpc_valid),
        .dnpc           (dnpc),
        .ic_fence_i     (ic_fence_i),
        .halt           (halt)
    );

endmodule

/* sim/tb_exu.sv */
`include "exu_defines.svh"

module tb_exu;
    timeunit 1ns;
    timeprecision 1ps;
    import exu_pkg::*;

    localparam int N_ALU    = 500;
    localparam int N_BR     = 300;
    localparam int N_SYS    = 200;
    localparam int N_MIX    = 400;
    localparam int N_CYCLES = 8 + 4 + N_ALU + N_BR + N_SYS + N_MIX + 2;

    logic clk;
    logic rst;
    logic idu_valid;
    logic lsu_ready;
    logic [`EXU_XLEN-1:0] pc, imm, src1, src2, csr_data;
    exu_class_e op_class;
    exu_op_u op;
    logic src1_is_pc, src2_is_imm, is_load, is_store, rf_we;
    logic [`EXU_REG_W-1:0] rd;
    logic exu_ready, exu_valid, lu_is_load, lu_is_store, lu_rf_we;
    logic ic_fence_i, dnpc_valid, halt;
    logic [`EXU_XLEN-1:0] result, store_data, csr_wdata, dnpc;
    logic [`EXU_REG_W-1:0] lu_rd;

    // expected stage register.
    logic exp_valid, exp_dnpc_valid, exp_fence, exp_halt, exp_load, exp_store_f, exp_rf_we;
    logic [`EXU_XLEN-1:0] exp_result, exp_store, exp_csr, exp_dnpc;
    logic [`EXU_REG_W-1:0] exp_rd;

    logic [31:0] rng_state;
    int checks;
    int errors;

    exu_top u_dut (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [31:0] model_alu(input logic [31:0] a, input logic [31:0] b,
                                              input alu_fn_e fn);
        case (fn)
            FN_ADD:    return a + b;
            FN_SUB:    return a - b;
            FN_SLL:    return a << b[4:0];
            FN_SLT:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            FN_SLTU:   return (a < b) ? 32'd1 : 32'd0;
            FN_XOR:    return a ^ b;
            FN_SRL:    return a >> b[4:0];
            FN_SRA:    return $signed(a) >>> b[4:0];
            FN_OR:     return a | b;
            FN_AND:    return a & b;
            FN_PASS_B: return b;
            default:   return 32'd0;
        endcase
    endfunction

    function automatic logic model_cmp(input logic [31:0] x, input logic [31:0] y, input cmp_e c);
        case (c)
            CMP_EQ:  return x == y;
            CMP_NE:  return x != y;
            CMP_LT:  return $signed(x) < $signed(y);
            CMP_GE:  return $signed(x) >= $signed(y);
            CMP_LTU: return x < y;
            default: return x >= y;
        endcase
    endfunction

    // reads the inputs the DUT samples on this edge and updates the expected register.
    task automatic model_edge();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] csr_wd;
        logic [31:0] target;
        logic redir;
        logic fence;
        logic stop;
        a      = src1_is_pc ? pc : src1;
        b      = src2_is_imm ? imm : src2;
        res    = model_alu(a, b, op.alu.fn);
        csr_wd = 32'd0;
        target = res;
        redir  = 1'b0;
        fence  = 1'b0;
        stop   = 1'b0;
        case (op_class)
            CLS_BRANCH: redir = model_cmp(src1, src2, op.alu.cmp);
            CLS_JUMP: begin
                target = (a + b) & ~32'd1; // jalr target with bit 0 cleared.
                res    = pc + 32'd4;
                redir  = 1'b1;
            end
            CLS_SYS: begin
                res    = 32'd0; // the op word carries flags, so no ALU function applies.
                target = csr_data;
                redir  = op.sys.ecall | op.sys.mret;
                fence  = op.sys.fence_i;
                stop   = op.sys.ebreak | op.sys.illegal;
                if (op.sys.csrrw) begin
                    csr_wd = src1;
                    res    = csr_data;
                end else if (op.sys.csrrs) begin
                    csr_wd = src1 | csr_data;
                    res    = csr_data;
                end
            end
            default: redir = 1'b0;
        endcase
        if (lsu_ready) begin
            exp_valid      = idu_valid;
            exp_dnpc_valid = idu_valid & redir;
            exp_fence      = idu_valid & fence;
            exp_halt       = idu_valid & stop;
            if (idu_valid) begin
                exp_result  = res;
                exp_csr     = csr_wd;
                exp_store   = src2;
                exp_load    = is_load;
                exp_store_f = is_store;
                exp_rf_we   = rf_we;
                exp_rd      = rd;
                exp_dnpc    = target;
            end
        end
    endtask

    task automatic drive_insn(input exu_class_e cls, input logic valid, input logic ready);
        exu_op_u o;
        logic [31:0] r;
        logic [31:0] s1;
        logic [7:0] flags;
        r     = next_rand();
        s1    = next_rand();
        flags = 8'h80 >> (r % 7); // one system flag, csrrw down to illegal.
        o     = '0;
        if (cls == CLS_SYS) begin
            o.sys = sys_fields_t'(flags);
        end else begin
            o.alu.fn  = (cls == CLS_ALU) ? alu_fn_e'(4'(r % 11)) : FN_ADD;
            o.alu.cmp = cmp_e'(3'((r >> 8) % 6));
        end
        idu_valid   <= valid;
        lsu_ready   <= ready;
        op_class    <= cls;
        op          <= o;
        pc          <= next_rand() & ~32'd3;
        imm         <= next_rand();
        src1        <= s1;
        src2        <= r[20] ? s1 : next_rand(); // equal operands now and then.
        csr_data    <= next_rand();
        src1_is_pc  <= (cls == CLS_BRANCH) | r[16];
        src2_is_imm <= (cls == CLS_BRANCH) | (cls == CLS_JUMP) | r[17];
        is_load     <= r[18];
        is_store    <= r[19];
        rf_we       <= r[21];
        rd          <= r[26:22];
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_outputs();
        compare("exu_ready", exu_ready, lsu_ready);
        compare("exu_valid", exu_valid, exp_valid);
        compare("result", result, exp_result);
        compare("store_data", store_data, exp_store);
        compare("csr_wdata", csr_wdata, exp_csr);
        compare("lu_is_load", lu_is_load, exp_load);
        compare("lu_is_store", lu_is_store, exp_store_f);
        compare("lu_rf_we", lu_rf_we, exp_rf_we);
        compare("lu_rd", lu_rd, exp_rd);
        compare("dnpc_valid", dnpc_valid, exp_dnpc_valid);
        compare("ic_fence_i", ic_fence_i, exp_fence);
        compare("halt", halt, exp_halt);
        if (exp_dnpc_valid) begin
            compare("dnpc", dnpc, exp_dnpc); // the target only means something when valid.
        end
    endtask

    task automatic step(input exu_class_e cls, input logic valid, input logic ready);
        @(posedge clk);
        model_edge();
        drive_insn(cls, valid, ready);
        @(negedge clk);
        check_outputs();
    endtask

    task automatic report_test(input string name, input int err_start);
        $display("test %s finished with %0d errors", name, errors - err_start);
    endtask

    initial begin
        int e0;
        logic [31:0] r;
        rng_state = 32'd15;
        checks = 0;
        errors = 0;
        rst = 1'b1;
        idu_valid = 1'b0;
        lsu_ready = 1'b0;
        {pc, imm, src1, src2, csr_data} = '0;
        op_class = CLS_ALU;
        op = '0;
        {src1_is_pc, src2_is_imm, is_load, is_store, rf_we} = '0;
        rd = '0;
        {exp_valid, exp_dnpc_valid, exp_fence, exp_halt, exp_load, exp_store_f, exp_rf_we} = '0;
        {exp_result, exp_store, exp_csr, exp_dnpc} = '0;
        exp_rd = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        e0 = errors;
        check_outputs();
        compare("dnpc", dnpc, 32'd0);
        repeat (4) step(CLS_ALU, 1'b0, 1'b1);
        report_test("reset", e0);

        e0 = errors;
        repeat (N_ALU) step(CLS_ALU, 1'b1, 1'b1);
        report_test("alu", e0);

        e0 = errors;
        repeat (N_BR) step((next_rand() % 3 != 0) ? CLS_BRANCH : CLS_JUMP, 1'b1, 1'b1);
        report_test("branch_jump", e0);

        e0 = errors;
        repeat (N_SYS) step(CLS_SYS, 1'b1, 1'b1);
        report_test("system", e0);

        e0 = errors;
        repeat (N_MIX) begin
            r = next_rand();
            step(exu_class_e'(r[1:0]), r[2], r[4:3] != 2'b00); // ready three times in four.
        end
        repeat (2) step(CLS_ALU, 1'b0, 1'b1); // drain the last instruction.
        report_test("backpressure", e0);

        $display("tests 5, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #((N_CYCLES + 100) * 10);
        $display("timeout: the run did not finish within %0d cycles", N_CYCLES + 100);
        $display("** FAIL **");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+rtl
rtl/exu_pkg.sv
rtl/exu_alu.sv
rtl/exu_branch.sv
rtl/exu_csr_wdata.sv
rtl/exu_ctrl.sv
rtl/exu_top.sv
sim/tb_exu.sv

/* Bender.yml */
package:
  name: exu

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/exu_pkg.sv
      - rtl/exu_alu.sv
      - rtl/exu_branch.sv
      - rtl/exu_csr_wdata.sv
      - rtl/exu_ctrl.sv
      - rtl/exu_top.sv
  - target: simulation
    files:
      - sim/tb_exu.sv
